/* Makefile */
# Verilator build and run for the response engine testbench

VERILATOR ?= verilator
TOP       ?= response_engine_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert -j 0
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG TIMESCALE VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "All checks passed" $(LOG); then \
		echo "Simulation ended without a pass line"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/glay_consts.svh */
// ------------------------------------------------
// Response path constants
// Port count, field widths, FIFO sizing and the
// reset-busy window shared by the design
// ------------------------------------------------

`ifndef GLAY_CONSTS_SVH
`define GLAY_CONSTS_SVH

// Memory receiver ports
`define GLAY_NUM_RECEIVERS 4

// Payload field widths
`define GLAY_ID_W 16
`define GLAY_CMD_W 2
`define GLAY_TAG_W 6
`define GLAY_COUNT_W 16

// Per-port input FIFO sizing
`define GLAY_IN_FIFO_DEPTH 16
`define GLAY_IN_PROG_THRESH 12

// Output cache FIFO sizing
`define GLAY_OUT_FIFO_DEPTH 32
`define GLAY_OUT_PROG_THRESH 16

// FIFO busy window after reset, in cycles
`define GLAY_RST_BUSY_CYCLES 4

`endif

/* hdl/glay_pkg.sv */
// ------------------------------------------------
// Response path types
// Packet layout, the two views of the data word,
// FIFO state bundles and the decoded result
// ------------------------------------------------

`include "glay_consts.svh"
`default_nettype none

package glay_pkg;

  // Command codes, 2'b11 is not assigned
  typedef enum logic [`GLAY_CMD_W-1:0] {
    CMD_NONE   = 2'b00,
    CMD_VERTEX = 2'b01,
    CMD_EDGE   = 2'b10
  } response_cmd_t;

  // ------------------------------------------------
  // Data word views
  // ------------------------------------------------
  // Vertex property read
  typedef struct packed {
    logic [`GLAY_ID_W-1:0] vertex_id;
    logic [`GLAY_ID_W-1:0] prop_value;
  } vertex_view_t;

  // Edge read
  typedef struct packed {
    logic [`GLAY_ID_W-1:0] src_id;
    logic [`GLAY_ID_W-1:0] dst_id;
  } edge_view_t;

  // Same 32 bits, meaning set by the command
  typedef union packed {
    vertex_view_t as_vertex;
    edge_view_t   as_edge;
  } response_data_u;

  // ------------------------------------------------
  // Packets
  // ------------------------------------------------
  typedef struct packed {
    response_cmd_t         cmd;
    logic [`GLAY_TAG_W-1:0] tag;
    response_data_u        data;
  } memory_response_payload_t;

  typedef struct packed {
    logic                     valid;
    memory_response_payload_t payload;
  } memory_response_t;

  // ------------------------------------------------
  // FIFO state towards the consumer
  // ------------------------------------------------
  typedef struct packed {
    logic rd_en;
  } fifo_state_in_t;

  typedef struct packed {
    logic empty;
    logic full;
    logic prog_full;
  } fifo_state_out_t;

  // Decoder result, ids are zero on a bad command
  typedef struct packed {
    logic                   valid;
    logic                   is_vertex;
    logic                   is_edge;
    logic                   bad_cmd;
    logic [`GLAY_TAG_W-1:0] tag;
    logic [`GLAY_ID_W-1:0]  first_id;
    logic [`GLAY_ID_W-1:0]  second_id;
  } decoded_response_t;

endpackage : glay_pkg

`default_nettype wire

/* hdl/response_arbiter_cache.sv */
// ------------------------------------------------
// Response arbiter cache
// Per-port input FIFOs merged by a round-robin
// arbiter into an output cache FIFO, drained by
// the consumer read enable. Produces grant levels
// and the FIFO setup flag
// ------------------------------------------------

`include "glay_consts.svh"
`default_nettype none

module response_arbiter_cache (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  glay_pkg::memory_response_t response_in [`GLAY_NUM_RECEIVERS],
  input  glay_pkg::fifo_state_in_t   fifo_response_signals_in,
  output glay_pkg::fifo_state_out_t  fifo_response_signals_out,
  output logic [`GLAY_NUM_RECEIVERS-1:0] arbiter_grant_out,
  output glay_pkg::memory_response_t response_out,
  output logic                       fifo_setup_signal
);

  import glay_pkg::*;

  localparam int N = `GLAY_NUM_RECEIVERS;
  // Cycles a receiver may still present after its grant drops
  localparam int GRANT_SLACK = 2;

  // Input side
  memory_response_t         in_reg [N];
  memory_response_payload_t in_dout [N];
  logic [N-1:0]             in_valid;
  logic [N-1:0]             in_empty;
  logic [N-1:0]             in_full;
  logic [N-1:0]             in_prog_full;
  logic [N-1:0]             in_busy;
  logic [N-1:0]             in_pop;

  // Arbiter
  memory_response_t arb_bus_in [N];
  memory_response_t arb_bus_out;
  logic [N-1:0]     arb_request;
  logic [N-1:0]     arb_grant;

  // Output cache
  memory_response_t         out_din_reg;
  memory_response_payload_t out_dout;
  memory_response_t         response_out_reg;
  logic                     out_valid;
  logic                     out_empty;
  logic                     out_full;
  logic                     out_prog_full;
  logic                     out_busy;
  logic                     out_pop;

  // ------------------------------------------------
  // Input registers
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      for (int i = 0; i < N; i++) begin
        in_reg[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        in_reg[i].valid <= response_in[i].valid;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < N; i++) begin
      in_reg[i].payload <= response_in[i].payload;
    end
  end

  // ------------------------------------------------
  // Per-port FIFOs
  // ------------------------------------------------
  for (genvar i = 0; i < N; i++) begin : g_port
    // No new arbitration once the output cache is nearly full
    assign arb_request[i] = ~in_empty[i] & ~out_prog_full;
    assign in_pop[i]      = arb_grant[i] & ~in_empty[i];
    assign arb_bus_in[i]  = {in_valid[i], in_dout[i]};

    response_fifo #(
      .DEPTH      (`GLAY_IN_FIFO_DEPTH),
      .PROG_THRESH(`GLAY_IN_PROG_THRESH)
    ) u_in_fifo (
      .ap_clk        (ap_clk),
      .areset_control(areset_control),
      .din           (in_reg[i].payload),
      .wr_en         (in_reg[i].valid),
      .rd_en         (in_pop[i]),
      .dout          (in_dout[i]),
      .valid         (in_valid[i]),
      .empty         (in_empty[i]),
      .full          (in_full[i]),
      .prog_full     (in_prog_full[i]),
      .rst_busy      (in_busy[i])
    );

    // Receiver honours the grant level within the slack
    a_grant_respected : assert property (@(posedge ap_clk) disable iff (areset_control)
      (!arbiter_grant_out[i]) [*GRANT_SLACK] |-> !response_in[i].valid)
      else $error("response on port %0d while grant low", i);
  end

  // ------------------------------------------------
  // Arbiter and output cache
  // ------------------------------------------------
  round_robin_arbiter #(
    .WIDTH(N)
  ) u_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request       (arb_request),
    .bus_in        (arb_bus_in),
    .grant         (arb_grant),
    .bus_out       (arb_bus_out)
  );

  // Extra stage ahead of the push
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_din_reg.valid <= 1'b0;
    end else begin
      out_din_reg.valid <= arb_bus_out.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_din_reg.payload <= arb_bus_out.payload;
  end

  assign out_pop = fifo_response_signals_in.rd_en & ~out_empty;

  response_fifo #(
    .DEPTH      (`GLAY_OUT_FIFO_DEPTH),
    .PROG_THRESH(`GLAY_OUT_PROG_THRESH)
  ) u_out_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (out_din_reg.payload),
    .wr_en         (out_din_reg.valid),
    .rd_en         (out_pop),
    .dout          (out_dout),
    .valid         (out_valid),
    .empty         (out_empty),
    .full          (out_full),
    .prog_full     (out_prog_full),
    .rst_busy      (out_busy)
  );

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  // Two register stages on the read side
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      response_out_reg.valid <= 1'b0;
      response_out.valid     <= 1'b0;
    end else begin
      response_out_reg.valid <= out_valid;
      response_out.valid     <= response_out_reg.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    response_out_reg.payload <= out_dout;
    response_out.payload     <= response_out_reg.payload;
  end

  // State, setup flag and grant levels
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_response_signals_out <= '{empty: 1'b1, full: 1'b0, prog_full: 1'b0};
      fifo_setup_signal         <= 1'b1;
      arbiter_grant_out         <= '0;
    end else begin
      fifo_response_signals_out.empty     <= out_empty;
      fifo_response_signals_out.full      <= out_full;
      fifo_response_signals_out.prog_full <= out_prog_full;
      fifo_setup_signal                   <= out_busy | (|in_busy);
      for (int i = 0; i < N; i++) begin
        // Port closes on its own level or on the output cache
        arbiter_grant_out[i] <= ~(in_prog_full[i] | in_full[i]) & ~out_prog_full
                                & ~out_busy & ~in_busy[i];
      end
    end
  end

endmodule : response_arbiter_cache

`default_nettype wire

/* hdl/response_decoder.sv */
// ------------------------------------------------
// Response decoder
// Reads the data word as vertex or edge by its
// command, registers the result and counts
// vertex and edge responses
// ------------------------------------------------

`include "glay_consts.svh"
`default_nettype none

module response_decoder (
  input  logic                          ap_clk,
  input  logic                          areset_control,
  input  glay_pkg::memory_response_t    response_in,
  output glay_pkg::decoded_response_t   result,
  output logic [`GLAY_COUNT_W-1:0]      vertex_count,
  output logic [`GLAY_COUNT_W-1:0]      edge_count
);

  import glay_pkg::*;

  decoded_response_t dec;

  // ------------------------------------------------
  // Command decode
  // ------------------------------------------------
  always_comb begin
    dec       = '0;
    dec.valid = response_in.valid;
    dec.tag   = response_in.payload.tag;
    case (response_in.payload.cmd)
      CMD_VERTEX: begin
        dec.is_vertex = 1'b1;
        dec.first_id  = response_in.payload.data.as_vertex.vertex_id;
        dec.second_id = response_in.payload.data.as_vertex.prop_value;
      end
      CMD_EDGE: begin
        dec.is_edge   = 1'b1;
        dec.first_id  = response_in.payload.data.as_edge.src_id;
        dec.second_id = response_in.payload.data.as_edge.dst_id;
      end
      // None or unassigned code, ids stay zero
      default: dec.bad_cmd = 1'b1;
    endcase
  end

  // Result register
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= dec.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    result.is_vertex <= dec.is_vertex;
    result.is_edge   <= dec.is_edge;
    result.bad_cmd   <= dec.bad_cmd;
    result.tag       <= dec.tag;
    result.first_id  <= dec.first_id;
    result.second_id <= dec.second_id;
  end

  // Counters, bad commands leave both alone
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      vertex_count <= '0;
      edge_count   <= '0;
    end else if (dec.valid) begin
      vertex_count <= vertex_count + `GLAY_COUNT_W'(dec.is_vertex);
      edge_count   <= edge_count + `GLAY_COUNT_W'(dec.is_edge);
    end
  end

endmodule : response_decoder

`default_nettype wire

/* hdl/response_engine_top.sv */
// ------------------------------------------------
// Response engine top
// Arbiter cache feeding the response decoder
// ------------------------------------------------

`include "glay_consts.svh"
`default_nettype none

module response_engine_top (
  input  logic                           ap_clk,
  input  logic                           areset_control,
  input  glay_pkg::memory_response_t     response_in [`GLAY_NUM_RECEIVERS],
  input  glay_pkg::fifo_state_in_t       fifo_response_signals_in,
  output glay_pkg::fifo_state_out_t      fifo_response_signals_out,
  output logic [`GLAY_NUM_RECEIVERS-1:0] arbiter_grant_out,
  output logic                           fifo_setup_signal,
  output glay_pkg::decoded_response_t    decoded_response,
  output logic [`GLAY_COUNT_W-1:0]       vertex_count,
  output logic [`GLAY_COUNT_W-1:0]       edge_count
);

  import glay_pkg::*;

  // Merged stream into the decoder
  memory_response_t cache_response_out;

  response_arbiter_cache u_arbiter_cache (
    .ap_clk                   (ap_clk),
    .areset_control           (areset_control),
    .response_in              (response_in),
    .fifo_response_signals_in (fifo_response_signals_in),
    .fifo_response_signals_out(fifo_response_signals_out),
    .arbiter_grant_out        (arbiter_grant_out),
    .response_out             (cache_response_out),
    .fifo_setup_signal        (fifo_setup_signal)
  );

  response_decoder u_decoder (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .response_in   (cache_response_out),
    .result        (decoded_response),
    .vertex_count  (vertex_count),
    .edge_count    (edge_count)
  );

endmodule : response_engine_top

`default_nettype wire

/* hdl/response_fifo.sv */
// ------------------------------------------------
// Synchronous response FIFO
// Circular buffer with registered read data, a
// valid strobe one cycle after each pop, a
// programmable full level and a busy window
// after reset
// ------------------------------------------------

`include "glay_consts.svh"
`default_nettype none

module response_fifo #(
  parameter int DEPTH       = 16,
  parameter int PROG_THRESH = 12
) (
  input  logic                               ap_clk,
  input  logic                               areset_control,
  input  glay_pkg::memory_response_payload_t din,
  input  logic                               wr_en,
  input  logic                               rd_en,
  output glay_pkg::memory_response_payload_t dout,
  output logic                               valid,
  output logic                               empty,
  output logic                               full,
  output logic                               prog_full,
  output logic                               rst_busy
);

  import glay_pkg::*;

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam int BW = $clog2(`GLAY_RST_BUSY_CYCLES + 1);

  memory_response_payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [BW-1:0] busy_cnt;
  logic          push;
  logic          pop;

  // Flags straight from the occupancy
  assign empty     = (count == '0);
  assign full      = (count == CW'(DEPTH));
  assign prog_full = (count >= CW'(PROG_THRESH));
  assign rst_busy  = (busy_cnt != '0);

  // Both sides locked out while busy
  assign push = wr_en & ~full & ~rst_busy;
  assign pop  = rd_en & ~empty & ~rst_busy;

  // ------------------------------------------------
  // Reset-busy window
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_cnt <= BW'(`GLAY_RST_BUSY_CYCLES);
    end else if (rst_busy) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // ------------------------------------------------
  // Pointers, occupancy and read strobe
  // ------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CW'(push) - CW'(pop);
      // Data shows up the cycle after the pop
      valid <= pop;
    end
  end

  // Storage and read register
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
    if (pop) begin
      dout <= mem[rd_ptr];
    end
  end

  // Producer has to respect the flow control upstream
  a_no_write_full : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(wr_en && full))
    else $error("response_fifo write while full");

  // Consumer side gating must keep reads off an empty FIFO
  a_no_read_empty : assert property (@(posedge ap_clk) disable iff (areset_control)
    !(rd_en && empty))
    else $error("response_fifo read while empty");

endmodule : response_fifo

`default_nettype wire

/* hdl/round_robin_arbiter.sv */
// ------------------------------------------------
// Round-robin bus arbiter
// Grants one requester per cycle and forwards the
// packet popped under the previous grant
// ------------------------------------------------

`default_nettype none

module round_robin_arbiter #(
  parameter int WIDTH = 4
) (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  logic [WIDTH-1:0]           request,
  input  glay_pkg::memory_response_t bus_in [WIDTH],
  output logic [WIDTH-1:0]           grant,
  output glay_pkg::memory_response_t bus_out
);

  import glay_pkg::*;

  localparam int IW = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  logic [IW-1:0]    last_q;
  logic [IW-1:0]    win_next;
  logic [WIDTH-1:0] grant_next;
  logic [WIDTH-1:0] grant_d1;
  memory_response_t bus_sel;

  // ------------------------------------------------
  // Priority search
  // ------------------------------------------------
  // Start one past the last winner and wrap around
  always_comb begin
    int   idx;
    logic found;
    grant_next = '0;
    win_next   = last_q;
    found      = 1'b0;
    for (int k = 1; k <= WIDTH; k++) begin
      idx = (int'(last_q) + k) % WIDTH;
      if (!found && request[idx]) begin
        found           = 1'b1;
        grant_next[idx] = 1'b1;
        win_next        = IW'(idx);
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant    <= '0;
      grant_d1 <= '0;
      last_q   <= IW'(WIDTH - 1);
    end else begin
      grant    <= grant_next;
      // Lines up with the FIFO read data
      grant_d1 <= grant;
      last_q   <= win_next;
    end
  end

  // ------------------------------------------------
  // Bus mux on the delayed grant
  // ------------------------------------------------
  always_comb begin
    bus_sel = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (grant_d1[i]) begin
        bus_sel = bus_in[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out.valid <= 1'b0;
    end else begin
      bus_out.valid <= bus_sel.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    bus_out.payload <= bus_sel.payload;
  end

  a_grant_onehot : assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(grant))
    else $error("arbiter grant not one-hot");

endmodule : round_robin_arbiter

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/glay_pkg.sv
hdl/response_fifo.sv
hdl/round_robin_arbiter.sv
hdl/response_arbiter_cache.sv
hdl/response_decoder.sv
hdl/response_engine_top.sv
sim/response_engine_tb.sv

/* sim/response_engine_tb.sv */
// ------------------------------------------------
// Response engine testbench
// Replays vectors from the tests file on the
// receiver ports, applies consumer back-pressure
// and scoreboards the decoded stream per port
// ------------------------------------------------

`include "glay_consts.svh"
`default_nettype none

module response_engine_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import glay_pkg::*;

  localparam int N                 = `GLAY_NUM_RECEIVERS;
  localparam int MAX_VEC           = 1 << `GLAY_TAG_W;
  localparam int RESET_CYCLES      = 16;
  localparam int CYCLES_PER_VECTOR = 50;
  localparam int unsigned LCG_SEED = 32'd77367;

  // DUT connections
  logic                     ap_clk;
  logic                     areset_control;
  memory_response_t         response_in [N];
  fifo_state_in_t           rd_ctrl;
  fifo_state_out_t          fifo_state;
  logic [N-1:0]             grant;
  logic                     fifo_setup;
  decoded_response_t        decoded;
  logic [`GLAY_COUNT_W-1:0] vertex_count;
  logic [`GLAY_COUNT_W-1:0] edge_count;

  // Vector table, indexed by tag
  string       vec_name [MAX_VEC];
  int          vec_port [MAX_VEC];
  logic [1:0]  vec_cmd [MAX_VEC];
  logic [31:0] vec_data [MAX_VEC];
  bit          vec_bp [MAX_VEC];
  bit          seen [MAX_VEC];

  // Tags in send order, one queue per port
  int exp_q [N][$];

  int num_vec;
  int exp_vertex_total;
  int exp_edge_total;
  int bp_total;
  int received;
  int errors;
  bit vectors_loaded;
  bit setup_done;
  bit bp_request;
  bit bp_released;
  bit grant_drop_seen;

  response_engine_top UUT (
    .ap_clk                   (ap_clk),
    .areset_control           (areset_control),
    .response_in              (response_in),
    .fifo_response_signals_in (rd_ctrl),
    .fifo_response_signals_out(fifo_state),
    .arbiter_grant_out        (grant),
    .fifo_setup_signal        (fifo_setup),
    .decoded_response         (decoded),
    .vertex_count             (vertex_count),
    .edge_count               (edge_count)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task automatic abort_run(input string reason);
    errors++;
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string test_name, input string what,
                             input int expected, input int actual);
    if (expected != actual) begin
      abort_run($sformatf("CHECK FAILED %s %s: expected %0h actual %0h",
                          test_name, what, expected, actual));
    end
  endtask

  // 32-bit LCG, upper bits returned
  function automatic int unsigned lcg_step(inout int unsigned state);
    state = state * 32'd1103515245 + 32'd12345;
    return state >> 16;
  endfunction

  task automatic clear_valids();
    for (int i = 0; i < N; i++) begin
      response_in[i].valid <= 1'b0;
    end
  endtask

  // One vector per line, lines starting with # skipped
  task automatic load_vectors();
    int          fd;
    int          n;
    int          port;
    int          cmd;
    int          bp;
    int unsigned data;
    int          bad_lines;
    string       line;
    string       name;
    bad_lines = 0;
    fd = $fopen("sim/response_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the test vector file sim/response_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %d %d %h %d", name, port, cmd, data, bp);
          if (n == 5 && port >= 0 && port < N && cmd >= 0 && cmd < 4
              && bp >= 0 && bp < 2 && num_vec < MAX_VEC) begin
            vec_name[num_vec] = name;
            vec_port[num_vec] = port;
            vec_cmd[num_vec]  = 2'(cmd);
            vec_data[num_vec] = data;
            vec_bp[num_vec]   = (bp == 1);
            exp_vertex_total += (cmd == 1) ? 1 : 0;
            exp_edge_total   += (cmd == 2) ? 1 : 0;
            bp_total         += bp;
            num_vec++;
          end else if (n > 0) begin
            bad_lines++;
          end
        end
      end
      $fclose(fd);
      if (bad_lines != 0 || num_vec == 0) begin
        abort_run("Test vector file has malformed lines or no vectors");
      end else begin
        vectors_loaded = 1'b1;
      end
    end
  endtask

  // ------------------------------------------------
  // Reset, stimulus and final checks
  // ------------------------------------------------
  initial begin : main
    memory_response_t pkt;
    int               gap;
    int               p;
    int               setup_cycles;
    int unsigned      gap_state;
    gap_state      = LCG_SEED;
    areset_control = 1'b1;
    rd_ctrl        = '0;
    for (int i = 0; i < N; i++) begin
      response_in[i] = '0;
    end
    load_vectors();

    repeat (RESET_CYCLES) @(posedge ap_clk);
    areset_control <= 1'b0;
    @(posedge ap_clk);
    check_value("reset", "grant", 0, int'(grant));
    check_value("reset", "fifo empty", 1, int'(fifo_state.empty));
    check_value("reset", "fifo prog_full", 0, int'(fifo_state.prog_full));
    // Busy window, nothing may come out of the decoder
    setup_cycles = 0;
    while (fifo_setup) begin
      check_value("reset", "decoded valid", 0, int'(decoded.valid));
      setup_cycles++;
      @(posedge ap_clk);
    end
    check_value("reset", "setup window", 1, int'(setup_cycles >= `GLAY_RST_BUSY_CYCLES));
    check_value("reset", "fifo empty", 1, int'(fifo_state.empty));
    setup_done = 1'b1;

    for (int k = 0; k < num_vec; k++) begin
      p = vec_port[k];
      if (vec_bp[k] && !bp_request) begin
        bp_request <= 1'b1;
      end
      // Idle gaps only outside the back-pressure burst
      gap = vec_bp[k] ? 0 : int'(lcg_step(gap_state) % 32'd4);
      repeat (gap) begin
        @(posedge ap_clk);
        clear_valids();
      end
      @(posedge ap_clk);
      clear_valids();
      while (!grant[p]) begin
        @(posedge ap_clk);
        clear_valids();
      end
      pkt.valid        = 1'b1;
      pkt.payload.cmd  = response_cmd_t'(vec_cmd[k]);
      pkt.payload.tag  = `GLAY_TAG_W'(k);
      pkt.payload.data = vec_data[k];
      response_in[p] <= pkt;
      exp_q[p].push_back(k);
    end
    @(posedge ap_clk);
    clear_valids();

    while (received < num_vec) begin
      @(posedge ap_clk);
    end
    repeat (4) @(posedge ap_clk);

    check_value("totals", "vertex_count", exp_vertex_total, int'(vertex_count));
    check_value("totals", "edge_count", exp_edge_total, int'(edge_count));
    check_value("totals", "fifo empty", 1, int'(fifo_state.empty));
    if (bp_total > 0) begin
      check_value("backpressure", "grant drop seen", 1, int'(grant_drop_seen));
    end
    if (errors == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      abort_run("Errors were recorded during the run");
    end
  end

  // ------------------------------------------------
  // Consumer read enable
  // ------------------------------------------------
  initial begin : rd_control
    int          release_wait;
    int unsigned rd_state;
    rd_state     = LCG_SEED;
    release_wait = -1;
    wait (setup_done);
    forever begin
      @(posedge ap_clk);
      if (bp_request && !bp_released) begin
        // Hold until the grants close, then a short random delay
        rd_ctrl.rd_en <= 1'b0;
        if (release_wait > 0) begin
          release_wait--;
        end else if (release_wait == 0) begin
          bp_released <= 1'b1;
        end else if (grant != '1) begin
          // Grants close because the output cache reached its level
          check_value("backpressure", "output prog_full", 1, int'(fifo_state.prog_full));
          grant_drop_seen = 1'b1;
          release_wait    = 4 + int'(lcg_step(rd_state) % 32'd8);
        end
      end else if (bp_released) begin
        rd_ctrl.rd_en <= ((lcg_step(rd_state) % 32'd4) != 0);
      end else begin
        rd_ctrl.rd_en <= 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Scoreboard
  // ------------------------------------------------
  initial begin : monitor
    int          tag;
    int          port;
    int          exp_tag;
    int          exp_first;
    int          exp_second;
    int          run_vertex;
    int          run_edge;
    bit          is_v;
    bit          is_e;
    logic [1:0]  cmd;
    logic [31:0] data;
    run_vertex = 0;
    run_edge   = 0;
    forever begin
      @(posedge ap_clk);
      if (setup_done) begin
        check_value("run", "output FIFO full", 0, int'(fifo_state.full));
      end
      if (!areset_control && decoded.valid === 1'b1) begin
        tag = int'(decoded.tag);
        if (tag >= num_vec) begin
          abort_run($sformatf("Decoded response carries tag %0d that was never sent", tag));
        end else if (seen[tag]) begin
          abort_run($sformatf("Response for %s came out twice", vec_name[tag]));
        end else if (exp_q[vec_port[tag]].size() == 0) begin
          abort_run($sformatf("Response for %s came out before it was sent", vec_name[tag]));
        end else begin
          port      = vec_port[tag];
          seen[tag] = 1'b1;
          exp_tag   = exp_q[port].pop_front();
          check_value(vec_name[tag], "port order tag", exp_tag, tag);
          // Expected decode from the command and data word
          cmd        = vec_cmd[tag];
          data       = vec_data[tag];
          is_v       = (cmd == 2'd1);
          is_e       = (cmd == 2'd2);
          exp_first  = (is_v || is_e) ? int'(data[31:16]) : 0;
          exp_second = (is_v || is_e) ? int'(data[15:0]) : 0;
          run_vertex += is_v ? 1 : 0;
          run_edge   += is_e ? 1 : 0;
          check_value(vec_name[tag], "is_vertex", int'(is_v), int'(decoded.is_vertex));
          check_value(vec_name[tag], "is_edge", int'(is_e), int'(decoded.is_edge));
          check_value(vec_name[tag], "bad_cmd", int'(!(is_v || is_e)), int'(decoded.bad_cmd));
          check_value(vec_name[tag], "first_id", exp_first, int'(decoded.first_id));
          check_value(vec_name[tag], "second_id", exp_second, int'(decoded.second_id));
          // Counters move with the result, bad commands leave them alone
          check_value(vec_name[tag], "vertex_count", run_vertex, int'(vertex_count));
          check_value(vec_name[tag], "edge_count", run_edge, int'(edge_count));
          received++;
        end
      end
    end
  end

  // Run limit scales with the vector count
  initial begin : watchdog
    wait (vectors_loaded);
    repeat (RESET_CYCLES + 4 * `GLAY_RST_BUSY_CYCLES + num_vec * CYCLES_PER_VECTOR) begin
      @(posedge ap_clk);
    end
    abort_run($sformatf("Timeout: only %0d of %0d responses arrived", received, num_vec));
  end

endmodule : response_engine_tb

`default_nettype wire

/* sim/response_tests.txt */
# name port cmd(0 none, 1 vertex, 2 edge, 3 unused) data(hex) backpressure
# vertex: id[31:16] prop[15:0], edge: src[31:16] dst[15:0]
vtx_p0_a 0 1 0012ABCD 0
edge_p1_a 1 2 00030007 0
vtx_p2_a 2 1 FFFF0001 0
edge_p3_a 3 2 1234FEDC 0
none_p0 0 0 DEADBEEF 0
unused_p1 1 3 CAFEF00D 0
vtx_p0_b 0 1 00010002 0
vtx_p0_c 0 1 00030004 0
edge_p2_b 2 2 7FFF8000 0
unused_p3 3 3 00000000 0
bp_v00 0 1 0100A001 1
bp_e01 1 2 0101A002 1
bp_v02 2 1 0102A003 1
bp_e03 3 2 0103A004 1
bp_v04 0 1 0104A005 1
bp_v05 0 1 0105A006 1
bp_e06 1 2 0106A007 1
bp_n07 2 0 0107A008 1
bp_e08 3 2 0108A009 1
bp_v09 1 1 0109A00A 1
bp_v10 2 1 010AA00B 1
bp_e11 0 2 010BA00C 1
bp_v12 3 1 010CA00D 1
bp_e13 1 2 010DA00E 1
bp_v14 0 1 010EA00F 1
bp_e15 2 2 010FA010 1
bp_x16 3 3 0110A011 1
bp_v17 1 1 0111A012 1
